/* nsc_cmd_top.f */
+incdir+design
design/nsc_cmd_pkg.sv
design/nsc_cmd_table.sv
design/nsc_phase_seq.sv
design/axi_wr_master.sv
design/nsc_cmd_top.sv
test/tb_clock.sv
test/tb_nsc_cmd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f nsc_cmd_top.f --top-module tb_nsc_cmd \
  -o sim_nsc_cmd &&
./obj_dir/sim_nsc_cmd | tee sim.log &&
grep -q "TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* test/tb_nsc_cmd.sv */
`timescale 1ns/1ps

module tb_nsc_cmd;

  localparam int          WAIT_LIMIT = 50;         // cycles per wait
  localparam logic [31:0] SP         = 32'h43C0_4000;
  localparam logic [31:0] CC         = 32'h43C0_3000;
  localparam logic [1:0]  OKAY       = 2'b00;
  localparam logic [1:0]  SLVERR     = 2'b10;

  // one expected write and how the responder treats it
  typedef struct packed {
    nsc_cmd_pkg::cmd_entry_t cmd;
    logic [2:0]              aw_dly;
    logic [2:0]              w_dly;
    logic [1:0]              resp;
    logic                    round_end;
  } row_t;

  logic                 ACLK;
  logic                 ARESETN;
  nsc_cmd_pkg::aw_req_t aw;
  logic                 awready;
  nsc_cmd_pkg::w_req_t  w;
  logic                 wready;
  nsc_cmd_pkg::b_rsp_t  b;
  logic                 bready;
  logic                 round_done;

  row_t   rows[$];
  integer seed = 32'h63c6;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     pulses = 0;        // cycles with round_done high

  tb_clock u_clock (.ACLK(ACLK), .ARESETN(ARESETN));

  nsc_cmd_top UUT (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .aw         (aw),
    .awready    (awready),
    .w          (w),
    .wready     (wready),
    .b          (b),
    .bready     (bready),
    .round_done (round_done)
  );

  always @(negedge ACLK) begin
    if (round_done === 1'b1) pulses <= pulses + 1;
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_entry(input string name, input nsc_cmd_pkg::cmd_entry_t got,
                             input nsc_cmd_pkg::cmd_entry_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got addr %h data %h, expected addr %h data %h",
               $time, name, got.addr, got.data, exp.addr, exp.data);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start_errs);
    tests_run++;
    if (errors != start_errs) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic add_row(input logic [31:0] addr, input logic [31:0] data,
                         input logic [1:0] resp, input logic round_end);
    logic [31:0] rnd;
    row_t        r;
    rnd         = $random(seed);
    r.cmd.addr  = addr;
    r.cmd.data  = data;
    r.aw_dly    = rnd[2:0];
    r.w_dly     = rnd[6:4];
    r.resp      = resp;
    r.round_end = round_end;
    rows.push_back(r);
  endtask

  // trigger, check and transfer lists of one round
  task automatic add_round(input bit with_retry);
    add_row(SP, 32'h1A4, OKAY, 1'b0);
    add_row(SP + 32'd4, 32'h100, OKAY, 1'b0);
    add_row(SP + 32'd8, 32'h100, OKAY, 1'b0);
    add_row(CC, 32'h1, OKAY, 1'b0);
    add_row(SP, 32'h130, OKAY, 1'b0);
    if (with_retry) add_row(SP + 32'd4, 32'h100, SLVERR, 1'b0);  // rejected once
    add_row(SP + 32'd4, 32'h100, OKAY, 1'b0);
    add_row(SP + 32'd8, 32'h1700_0100, OKAY, 1'b0);
    add_row(32'h1700_0100, 32'h0, OKAY, 1'b0);
    add_row(CC, 32'h1, OKAY, 1'b0);
    add_row(SP, 32'h338, OKAY, 1'b0);
    add_row(SP + 32'd4, 32'h100, OKAY, 1'b0);
    add_row(SP + 32'd8, 32'h100, OKAY, 1'b0);
    add_row(SP + 32'd12, 32'h4581_0000, OKAY, 1'b0);
    add_row(SP + 32'd16, 32'h4580_0100, OKAY, 1'b0);
    add_row(SP + 32'd20, 32'h1700_0200, OKAY, 1'b0);
    add_row(SP + 32'd24, 32'h1700_0000, OKAY, 1'b1);
  endtask

  function automatic logic chan_valid(input bit is_w);
    return is_w ? w.valid : aw.valid;
  endfunction

  function automatic logic [31:0] chan_word(input bit is_w);
    return is_w ? w.data : aw.addr;
  endfunction

  task automatic check_hold(input bit is_w, input logic [31:0] word);
    check_bit(is_w ? "w.valid" : "aw.valid", chan_valid(is_w), 1'b1);
    check_word(is_w ? "w.data" : "aw.addr", chan_word(is_w), word);
    if (!is_w && w.valid) report_error("w.valid rose before the address transfer");
  endtask

  // wait for valid, stall for dly cycles, then take one transfer
  task automatic accept(input bit is_w, input logic [2:0] dly, output logic [31:0] word,
                        output bit ok);
    int n;
    ok   = 1'b0;
    word = '0;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge ACLK);
      if (!is_w && w.valid) report_error("w.valid rose before the address transfer");
      if (chan_valid(is_w)) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      report_error($sformatf("timed out waiting for %s.valid", is_w ? "w" : "aw"));
    end else begin
      word = chan_word(is_w);
      for (n = 0; n < int'(dly); n++) begin
        @(negedge ACLK);
        check_hold(is_w, word);
      end
      @(posedge ACLK);
      if (is_w) wready <= 1'b1;
      else awready <= 1'b1;
      @(negedge ACLK);
      check_hold(is_w, word);
      @(posedge ACLK);                       // transfer happens on this edge
      if (is_w) wready <= 1'b0;
      else awready <= 1'b0;
    end
  endtask

  task automatic respond(input logic [1:0] code, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge ACLK);
      if (bready) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      report_error("timed out waiting for bready");
    end else begin
      @(posedge ACLK);
      b <= '{valid: 1'b1, resp: code};
      @(posedge ACLK);
      b <= '0;
      @(negedge ACLK);                       // round_done visible here
    end
  endtask

  initial begin
    int                      n;
    int                      start_errs;
    bit                      ok;
    logic [31:0]             aw_word;
    logic [31:0]             w_word;
    nsc_cmd_pkg::cmd_entry_t got;
    awready <= 1'b0;
    wready  <= 1'b0;
    b       <= '0;
    add_round(1'b1);
    add_round(1'b0);

    start_errs = errors;
    for (n = 0; n < WAIT_LIMIT && ARESETN !== 1'b0; n++) begin
      @(negedge ACLK);
      if (ARESETN) begin
        check_bit("aw.valid", aw.valid, 1'b0);
        check_bit("w.valid", w.valid, 1'b0);
        check_bit("bready", bready, 1'b0);
        check_bit("round_done", round_done, 1'b0);
      end
    end
    ok = (ARESETN === 1'b0);
    if (!ok) report_error("reset was never released");
    finish_test("outputs idle in reset", start_errs);

    for (int i = 0; i < rows.size() && ok; i++) begin
      start_errs = errors;
      accept(1'b0, rows[i].aw_dly, aw_word, ok);
      if (ok) accept(1'b1, rows[i].w_dly, w_word, ok);
      if (ok) respond(rows[i].resp, ok);
      if (ok) begin
        got.addr = aw_word;
        got.data = w_word;
        check_entry("aw.addr/w.data", got, rows[i].cmd);
        check_bit("round_done", round_done, rows[i].round_end);
      end
      finish_test($sformatf("write %0d to %h", i, rows[i].cmd.addr), start_errs);
    end

    if (ok) begin
      @(negedge ACLK);
      start_errs = errors;
      if (pulses != 2) report_error($sformatf("round_done high for %0d cycles, not 2", pulses));
      finish_test("round_done pulse count", start_errs);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && ok) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic ACLK,
  output logic ARESETN
);

  initial ACLK = 1'b0;
  always #50 ACLK = ~ACLK;  // 100 ns period

  initial begin
    ARESETN <= 1'b1;        // reset is active high
    repeat (5) @(posedge ACLK);
    ARESETN <= 1'b0;
  end

endmodule

/* design/nsc_cmd_top.sv */
`timescale 1ns/1ps
`include "nsc_cmd_cfg.svh"

module nsc_cmd_top (
  input  logic                  ACLK,
  input  logic                  ARESETN,
  output nsc_cmd_pkg::aw_req_t  aw,
  input  logic                  awready,
  output nsc_cmd_pkg::w_req_t   w,
  input  logic                  wready,
  input  nsc_cmd_pkg::b_rsp_t   b,
  output logic                  bready,
  output logic                  round_done
);

  nsc_cmd_pkg::nsc_phase_e phase;
  logic [`NSC_IDX_W-1:0]   idx;
  nsc_cmd_pkg::cmd_entry_t entry;    // table lookup
  logic                    last;
  nsc_cmd_pkg::cmd_entry_t req;      // write handed to the master
  logic                    req_valid;
  logic                    wr_done;
  logic                    wr_ok;

  nsc_phase_seq u_seq (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .phase      (phase),
    .idx        (idx),
    .entry      (entry),
    .last       (last),
    .req        (req),
    .req_valid  (req_valid),
    .wr_done    (wr_done),
    .wr_ok      (wr_ok),
    .round_done (round_done)
  );

  nsc_cmd_table u_table (
    .phase (phase),
    .idx   (idx),
    .entry (entry),
    .last  (last)
  );

  axi_wr_master u_wr (
    .ACLK      (ACLK),
    .ARESETN   (ARESETN),
    .req       (req),
    .req_valid (req_valid),
    .aw        (aw),
    .awready   (awready),
    .w         (w),
    .wready    (wready),
    .b         (b),
    .bready    (bready),
    .wr_done   (wr_done),
    .wr_ok     (wr_ok)
  );

endmodule

/* design/axi_wr_master.sv */
`timescale 1ns/1ps

module axi_wr_master (
  input  logic                     ACLK,
  input  logic                     ARESETN,
  input  nsc_cmd_pkg::cmd_entry_t  req,
  input  logic                     req_valid,
  output nsc_cmd_pkg::aw_req_t     aw,
  input  logic                     awready,
  output nsc_cmd_pkg::w_req_t      w,
  input  logic                     wready,
  input  nsc_cmd_pkg::b_rsp_t      b,
  output logic                     bready,
  output logic                     wr_done,
  output logic                     wr_ok
);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_ADDR = 2'd1,  // aw.valid up
    ST_DATA = 2'd2,  // w.valid up
    ST_RESP = 2'd3   // bready up
  } wr_state_e;

  wr_state_e               state;
  nsc_cmd_pkg::cmd_entry_t req_q;  // latched write

  always_ff @(posedge ACLK or posedge ARESETN) begin
    if (ARESETN) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (req_valid) state <= ST_ADDR;
        ST_ADDR: if (awready) state <= ST_DATA;
        ST_DATA: if (wready) state <= ST_RESP;
        default: if (b.valid) state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (state == ST_IDLE && req_valid) begin
      req_q <= req;
    end
  end

  // payload comes straight from the latch, so it holds while stalled
  assign aw.valid = (state == ST_ADDR);
  assign aw.addr  = req_q.addr;
  assign w.valid  = (state == ST_DATA);
  assign w.data   = req_q.data;
  assign bready   = (state == ST_RESP);

  assign wr_done = bready && b.valid;                // B transfer
  assign wr_ok   = wr_done && (b.resp == RESP_OKAY);

  aw_stall_hold: assert property (@(posedge ACLK) disable iff (ARESETN)
    aw.valid && !awready |=> aw.valid && $stable(aw.addr));
  w_stall_hold: assert property (@(posedge ACLK) disable iff (ARESETN)
    w.valid && !wready |=> w.valid && $stable(w.data));

endmodule

/* design/nsc_phase_seq.sv */
`timescale 1ns/1ps
`include "nsc_cmd_cfg.svh"

module nsc_phase_seq (
  input  logic                     ACLK,
  input  logic                     ARESETN,
  output nsc_cmd_pkg::nsc_phase_e  phase,
  output logic [`NSC_IDX_W-1:0]    idx,
  input  nsc_cmd_pkg::cmd_entry_t  entry,
  input  logic                     last,
  output nsc_cmd_pkg::cmd_entry_t  req,
  output logic                     req_valid,
  input  logic                     wr_done,
  input  logic                     wr_ok,
  output logic                     round_done
);

  nsc_cmd_pkg::nsc_phase_e phase_q;
  logic [`NSC_IDX_W-1:0]   idx_q;
  logic                    last_q;   // entry in flight closes its phase
  logic                    issue;
  logic                    wr_out;   // write outstanding at the master

  // phase and idx point at the entry to issue next, so the table
  // answers in the same cycle as the response
  always_comb begin
    phase = phase_q;
    idx   = idx_q;
    issue = 1'b0;
    if (phase_q == nsc_cmd_pkg::PH_IDLE) begin
      phase = nsc_cmd_pkg::PH_TRIGGER;  // new round
      idx   = '0;
      issue = 1'b1;
    end else if (wr_done) begin
      issue = 1'b1;                     // error response reissues as is
      if (wr_ok && !last_q) begin
        idx = idx_q + 1'b1;
      end else if (wr_ok) begin
        idx = '0;
        case (phase_q)
          nsc_cmd_pkg::PH_TRIGGER: phase = nsc_cmd_pkg::PH_CHECK;
          nsc_cmd_pkg::PH_CHECK:   phase = nsc_cmd_pkg::PH_TRANSFER;
          default: begin
            phase = nsc_cmd_pkg::PH_IDLE;  // one idle cycle between rounds
            issue = 1'b0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge ACLK or posedge ARESETN) begin
    if (ARESETN) begin
      phase_q    <= nsc_cmd_pkg::PH_IDLE;
      idx_q      <= '0;
      req_valid  <= 1'b0;
      round_done <= 1'b0;
      wr_out     <= 1'b0;
    end else begin
      phase_q    <= phase;
      idx_q      <= idx;
      req_valid  <= issue;
      round_done <= wr_done && wr_ok && last_q && (phase_q == nsc_cmd_pkg::PH_TRANSFER);
      if (req_valid) begin
        wr_out <= 1'b1;
      end else if (wr_done) begin
        wr_out <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (issue) begin
      req    <= entry;
      last_q <= last;
    end
  end

  // one transaction at a time between sequencer and master
  no_req_in_flight: assert property (@(posedge ACLK) disable iff (ARESETN)
    req_valid |-> !wr_out);
  done_needs_req: assert property (@(posedge ACLK) disable iff (ARESETN)
    wr_done |-> wr_out);

endmodule

/* design/nsc_cmd_table.sv */
`timescale 1ns/1ps
`include "nsc_cmd_cfg.svh"

module nsc_cmd_table (
  input  nsc_cmd_pkg::nsc_phase_e  phase,
  input  logic [`NSC_IDX_W-1:0]    idx,
  output nsc_cmd_pkg::cmd_entry_t  entry,
  output logic                     last
);

  localparam logic [31:0] SP_ADDR = `NSC_BASE + `NSC_SP_OFS;
  localparam logic [31:0] CC_ADDR = `NSC_BASE + `NSC_CC_OFS;

  logic [`NSC_IDX_W-1:0] final_idx;  // index of the closing write

  always_comb begin
    entry = '0;
    case (phase)
      nsc_cmd_pkg::PH_TRIGGER: begin
        case (int'(idx))
          0:       entry = '{addr: SP_ADDR,         data: `NSC_OP_TRIGGER};
          1:       entry = '{addr: SP_ADDR + 32'd4, data: `NSC_WAY_ROW};   // way
          2:       entry = '{addr: SP_ADDR + 32'd8, data: `NSC_WAY_ROW};   // row
          default: entry = '{addr: CC_ADDR,         data: `NSC_DONE_FLAG};
        endcase
      end
      nsc_cmd_pkg::PH_CHECK: begin
        case (int'(idx))
          0:       entry = '{addr: SP_ADDR,         data: `NSC_OP_CHECK};
          1:       entry = '{addr: SP_ADDR + 32'd4, data: `NSC_WAY_ROW};
          2:       entry = '{addr: SP_ADDR + 32'd8, data: `NSC_FLAG_STATUS}; // report pointer
          3:       entry = '{addr: `NSC_FLAG_STATUS, data: 32'h0};           // clear old report
          default: entry = '{addr: CC_ADDR,         data: `NSC_DONE_FLAG};
        endcase
      end
      nsc_cmd_pkg::PH_TRANSFER: begin
        case (int'(idx))
          0:       entry = '{addr: SP_ADDR,          data: `NSC_OP_TRANSFER};
          1:       entry = '{addr: SP_ADDR + 32'd4,  data: `NSC_WAY_ROW};
          2:       entry = '{addr: SP_ADDR + 32'd8,  data: `NSC_WAY_ROW};
          3:       entry = '{addr: SP_ADDR + 32'd12, data: `NSC_BUF_ADDR};
          4:       entry = '{addr: SP_ADDR + 32'd16, data: `NSC_ECC_ADDR};
          5:       entry = '{addr: SP_ADDR + 32'd20, data: `NSC_FLAG_ERROR};
          default: entry = '{addr: SP_ADDR + 32'd24, data: `NSC_FLAG_COMPLETE};
        endcase
      end
      default: entry = '0;  // idle issues nothing
    endcase
  end

  always_comb begin
    case (phase)
      nsc_cmd_pkg::PH_TRIGGER:  final_idx = `NSC_IDX_W'(`NSC_TRIG_LEN - 1);
      nsc_cmd_pkg::PH_CHECK:    final_idx = `NSC_IDX_W'(`NSC_CHECK_LEN - 1);
      nsc_cmd_pkg::PH_TRANSFER: final_idx = `NSC_IDX_W'(`NSC_XFER_LEN - 1);
      default:                  final_idx = '0;
    endcase
  end

  assign last = (phase != nsc_cmd_pkg::PH_IDLE) && (idx == final_idx);

  // the sequencer must wrap to the next phase at the closing write
  always_comb begin
    idx_in_range: assert (idx <= final_idx)
      else $error("nsc_cmd_table: index %0d past end of phase %0d", idx, phase);
  end

endmodule

/* design/nsc_cmd_pkg.sv */
package nsc_cmd_pkg;

  // phase of one command round
  typedef enum logic [1:0] {
    PH_IDLE     = 2'd0,
    PH_TRIGGER  = 2'd1,
    PH_CHECK    = 2'd2,
    PH_TRANSFER = 2'd3
  } nsc_phase_e;

  // one single-word register write
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } cmd_entry_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } aw_req_t;          // write address, master to slave

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } w_req_t;           // write data, master to slave

  typedef struct packed {
    logic       valid;
    logic [1:0] resp;  // 2'b00 is OKAY
  } b_rsp_t;

endpackage

/* design/nsc_cmd_cfg.svh */
`ifndef NSC_CMD_CFG_SVH
`define NSC_CMD_CFG_SVH

// controller register map
`define NSC_BASE          32'h43C0_0000
`define NSC_SP_OFS        32'h0000_4000  // parameter page
`define NSC_CC_OFS        32'h0000_3000  // command control

// flag words in system memory
`define NSC_FLAG_COMPLETE 32'h1700_0000
`define NSC_FLAG_STATUS   32'h1700_0100
`define NSC_FLAG_ERROR    32'h1700_0200

// opcodes
`define NSC_OP_TRIGGER    32'h0000_01A4
`define NSC_OP_CHECK      32'h0000_0130
`define NSC_OP_TRANSFER   32'h0000_0338

`define NSC_WAY_ROW       32'h0000_0100  // same value for way and row
`define NSC_DONE_FLAG     32'h0000_0001

// data buffers
`define NSC_BUF_ADDR      32'h4581_0000
`define NSC_ECC_ADDR      32'h4580_0100

// writes per phase
`define NSC_TRIG_LEN      4
`define NSC_CHECK_LEN     5
`define NSC_XFER_LEN      7

`define NSC_IDX_W         3

`endif
